//--- dataPath_vectors.txt
# op fn addr(hex) srcA srcB dest data(hex) result(hex) flags(hex: zero neg carry ovf)
# op 0 memwrite 1 load 2 store 3 alu; fn 0 add 1 sub 2 and 3 or 4 xor 5 slt 6 passa 7 passb
0 0 000 0 0 0 7fffffff 7fffffff 0
0 0 7ff 0 0 0 ffffffff ffffffff 0
0 0 005 0 0 0 00000001 00000001 0
0 0 064 0 0 0 fffffff0 fffffff0 0
1 0 000 0 0 1 00000000 7fffffff 0
1 0 7ff 0 0 2 00000000 ffffffff 0
1 0 005 0 0 3 00000000 00000001 0
1 0 064 0 0 4 00000000 fffffff0 0
2 0 0c8 1 0 0 00000000 7fffffff 0
1 0 0c8 0 0 5 00000000 7fffffff 0
1 0 000 0 0 6 00000000 7fffffff 0
3 0 000 1 3 7 00000000 80000000 5
3 0 000 2 3 8 00000000 00000000 a
3 1 000 5 6 9 00000000 00000000 a
3 2 000 4 1 10 00000000 7ffffff0 0
3 3 000 4 3 11 00000000 fffffff1 4
3 4 000 1 2 12 00000000 80000000 4
3 5 000 4 3 13 00000000 00000001 0
3 5 000 3 4 14 00000000 00000000 8
3 6 000 7 0 15 00000000 80000000 4
3 7 000 0 4 16 00000000 fffffff0 4
1 0 005 0 0 0 00000000 00000001 0
3 6 000 0 0 17 00000000 00000000 8

//--- src.f
+incdir+.
dataPathPkg.sv
wordMemory.sv
registerFile.sv
alu.sv
sequencer.sv
dataPathTop.sv
tbClock.sv
dataPath_asserts.sv
dataPathTb.sv

//--- Makefile
SRCS := $(shell grep -v '^+' src.f)

obj_dir/VdataPathTb: src.f $(SRCS) dataPath_defines.svh
	verilator --binary --timing --assert -f src.f --top-module dataPathTb

run: obj_dir/VdataPathTb dataPath_vectors.txt
	./obj_dir/VdataPathTb | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- dataPathTb.sv
`timescale 1ns/10ps
`include "dataPath_defines.svh"

module dataPathTb;

	localparam int MAX_VEC = 64;

	logic                  clk;
	logic                  rst;
	logic                  cmdValid;
	dataPathPkg::dpCommand cmd;
	logic                  busy;
	logic                  done;
	logic [`WORD_W-1:0]    result;
	dataPathPkg::aluFlags  flags;

	dataPathPkg::dpCommand vecCmd [MAX_VEC];
	logic [`WORD_W-1:0]    vecResult [MAX_VEC];
	logic [3:0]            vecFlags [MAX_VEC];
	int numVec = 0;
	int cycleLimit = 0;
	int cycles = 0;
	int errors = 0;
	int failedTests = 0;

	tbClock clockGen_i (.clk(clk), .rst(rst));

	dataPathTop dataPathTop_i (
		.clk(clk), .rst(rst), .cmdValid(cmdValid), .cmd(cmd),
		.busy(busy), .done(done), .result(result), .flags(flags)
	);

	bind sequencer dataPathAsserts asserts_i (
		.clk(clk), .rst(rst), .accept(accept), .busy(busy), .done(done),
		.regWrite(regWrite), .regWriteSel(regWriteSel), .cur(cur)
	);

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycleLimit > 0 && cycles >= cycleLimit) begin
			$display("Timeout: the run did not finish within %0d clock cycles.", cycleLimit);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	task automatic checkValue(input string testName, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected) begin
			$display("ERROR %s %s: expected %h, actual %h", testName, what, expected, actual);
			errors++;
		end
	endtask

	task automatic readVectors();
		int fd;
		int n;
		string line;
		int op, fn, srcA, srcB, dest;
		logic [31:0] addr, data, expResult, expFlags;
		dataPathPkg::dpCommand c;
		fd = $fopen("dataPath_vectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open dataPath_vectors.txt for reading.");
		end else begin
			while (!$feof(fd) && numVec < MAX_VEC) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1 && line.getc(0) != "#") begin
					n = $sscanf(line, "%d %d %h %d %d %d %h %h %h", op, fn, addr,
						srcA, srcB, dest, data, expResult, expFlags);
					if (n == 9) begin
						c.op = dataPathPkg::cmdOp'(op[1:0]);
						c.fn = dataPathPkg::aluOp'(fn[2:0]);
						c.addr = addr[`MEM_ADDR_W-1:0];
						c.srcA = srcA[`REG_SEL_W-1:0];
						c.srcB = srcB[`REG_SEL_W-1:0];
						c.dest = dest[`REG_SEL_W-1:0];
						c.data = data;
						vecCmd[numVec] = c;
						vecResult[numVec] = expResult;
						vecFlags[numVec] = expFlags[3:0];
						numVec++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic runVector(input int idx);
		dataPathPkg::dpCommand c;
		dataPathPkg::dpCommand poke;
		dataPathPkg::cmdOp opv;
		string name;
		int latency;
		int expLatency;
		logic gotDone;
		c = vecCmd[idx];
		opv = c.op;
		name = $sformatf("vec%0d_%s", idx + 1, opv.name());
		expLatency = (c.op == dataPathPkg::CMD_LOAD) ? 2 : 1;
		poke = '0;
		poke.op = dataPathPkg::CMD_MEMWRITE;
		poke.addr = c.addr;
		poke.data = ~vecResult[idx]; // Would show up on a later load if it got in.
		errors = 0;
		@(posedge clk);
		cmdValid <= 1'b1;
		cmd <= c;
		@(posedge clk);
		if (c.op == dataPathPkg::CMD_LOAD) begin
			cmd <= poke; // Strobe stays up through the busy cycle.
		end else begin
			cmdValid <= 1'b0;
		end
		latency = 0;
		gotDone = 1'b0;
		while (!gotDone && latency < 4) begin
			@(negedge clk);
			latency++;
			// Busy covers every cycle after the accept up to the done cycle.
			checkValue(name, "busy", (latency < expLatency) ? 32'd1 : 32'd0, {31'd0, busy});
			if (done) begin
				gotDone = 1'b1;
			end else begin
				@(posedge clk);
				cmdValid <= 1'b0;
			end
		end
		if (!gotDone) begin
			$display("%s: done did not arrive within 4 cycles of acceptance.", name);
			errors++;
		end else begin
			checkValue(name, "latency", expLatency, latency);
			checkValue(name, "result", vecResult[idx], result);
			if (c.op == dataPathPkg::CMD_ALU) begin
				checkValue(name, "flags", {28'd0, vecFlags[idx]}, {28'd0, flags});
			end
		end
		if (errors == 0) begin
			$display("PASS %s", name);
		end else begin
			$display("FAIL %s", name);
			failedTests++;
		end
	endtask

	initial begin
		cmdValid = 1'b0;
		cmd = '0;
		readVectors();
		cycleLimit = 4 * numVec + 20;
		@(negedge rst);
		for (int i = 0; i < numVec; i++) begin
			runVector(i);
		end
		$display("%0d tests, %0d passed, %0d failed", numVec, numVec - failedTests, failedTests);
		if (numVec > 0 && failedTests == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- dataPath_asserts.sv
`timescale 1ns/10ps
`include "dataPath_defines.svh"

module dataPathAsserts (
	input logic                  clk,
	input logic                  rst,
	input logic                  accept,
	input logic                  busy,
	input logic                  done,
	input logic                  regWrite,
	input logic [`REG_SEL_W-1:0] regWriteSel,
	input dataPathPkg::dpCommand cur
);

	donePulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
		else $error("done stayed high for more than one cycle");

	busyNotDone: assert property (@(posedge clk) disable iff (rst) !(busy && done))
		else $error("busy and done were high together");

	noLoadIntoZero: assert property (@(posedge clk) disable iff (rst)
		!(regWrite && regWriteSel == '0 && cur.op == dataPathPkg::CMD_LOAD))
		else $error("a load wrote register 0");

	// No done one cycle after the accept means it must come on the second.
	doneAfterAccept: assert property (@(posedge clk) disable iff (rst)
		$past(accept, 2) && !$past(done) |-> done)
		else $error("done did not follow an accepted command within two cycles");

endmodule

//--- tbClock.sv
`timescale 1ns/10ps

module tbClock (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period.
	end

	initial begin
		rst = 1'b1;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

//--- dataPathTop.sv
`timescale 1ns/10ps
`include "dataPath_defines.svh"

module dataPathTop (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  cmdValid,
	input  dataPathPkg::dpCommand cmd,
	output logic                  busy,
	output logic                  done,
	output logic [`WORD_W-1:0]    result,
	output dataPathPkg::aluFlags  flags
);

	logic [`MEM_ADDR_W-1:0] memAddr;
	logic                   memWrite;
	logic [`WORD_W-1:0]     memWriteData;
	logic [`WORD_W-1:0]     memReadData;
	logic [`REG_SEL_W-1:0]  selA;
	logic [`REG_SEL_W-1:0]  selB;
	logic                   regWrite;
	logic [`REG_SEL_W-1:0]  regWriteSel;
	logic [`WORD_W-1:0]     regWriteData;
	logic [`WORD_W-1:0]     busA;
	logic [`WORD_W-1:0]     busB;
	dataPathPkg::aluOp      aluCtrl;
	logic [`WORD_W-1:0]     aluOut;
	dataPathPkg::aluFlags   aluFlagsW;

	wordMemory memory_i (
		.clk(clk), .addr(memAddr), .writeEn(memWrite),
		.writeData(memWriteData), .readData(memReadData)
	);

	registerFile regFile_i (
		.clk(clk), .rst(rst), .selA(selA), .selB(selB),
		.writeEn(regWrite), .writeSel(regWriteSel), .writeData(regWriteData),
		.busA(busA), .busB(busB)
	);

	alu alu_i (.a(busA), .b(busB), .ctrl(aluCtrl), .y(aluOut), .flags(aluFlagsW));

	sequencer sequencer_i (
		.clk(clk), .rst(rst), .cmdValid(cmdValid), .cmd(cmd),
		.busy(busy), .done(done), .result(result), .flags(flags),
		.memAddr(memAddr), .memWrite(memWrite), .memWriteData(memWriteData),
		.memReadData(memReadData), .selA(selA), .selB(selB), .aluCtrl(aluCtrl),
		.regWrite(regWrite), .regWriteSel(regWriteSel), .regWriteData(regWriteData),
		.busA(busA), .aluOut(aluOut), .aluFlagsIn(aluFlagsW)
	);

endmodule

//--- sequencer.sv
`timescale 1ns/10ps
`include "dataPath_defines.svh"

module sequencer (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   cmdValid,
	input  dataPathPkg::dpCommand  cmd,
	output logic                   busy,
	output logic                   done,
	output logic [`WORD_W-1:0]     result,
	output dataPathPkg::aluFlags   flags,
	output logic [`MEM_ADDR_W-1:0] memAddr,
	output logic                   memWrite,
	output logic [`WORD_W-1:0]     memWriteData,
	input  logic [`WORD_W-1:0]     memReadData,
	output logic [`REG_SEL_W-1:0]  selA,
	output logic [`REG_SEL_W-1:0]  selB,
	output dataPathPkg::aluOp      aluCtrl,
	output logic                   regWrite,
	output logic [`REG_SEL_W-1:0]  regWriteSel,
	output logic [`WORD_W-1:0]     regWriteData,
	input  logic [`WORD_W-1:0]     busA,
	input  logic [`WORD_W-1:0]     aluOut,
	input  dataPathPkg::aluFlags   aluFlagsIn
);

	dataPathPkg::seqState  state;
	dataPathPkg::seqState  step;
	dataPathPkg::seqState  stateNext;
	dataPathPkg::dpCommand cmdReg;
	dataPathPkg::dpCommand cur;
	logic                  accept;
	logic                  writing;

	assign busy = (state == dataPathPkg::SEQ_WRITEBACK);
	assign done = (state == dataPathPkg::SEQ_DONE);
	assign accept = cmdValid && !busy;
	assign cur = accept ? cmd : cmdReg; // Fresh command acts in its accept cycle.

	// What the datapath does in this cycle.
	always_comb begin
		if (accept && cmd.op == dataPathPkg::CMD_LOAD) begin
			step = dataPathPkg::SEQ_READ;
		end else if (accept || state == dataPathPkg::SEQ_WRITEBACK) begin
			step = dataPathPkg::SEQ_WRITEBACK;
		end else begin
			step = dataPathPkg::SEQ_IDLE;
		end
	end

	always_comb begin
		case (step)
			dataPathPkg::SEQ_READ: stateNext = dataPathPkg::SEQ_WRITEBACK;
			dataPathPkg::SEQ_WRITEBACK: stateNext = dataPathPkg::SEQ_DONE;
			default: stateNext = dataPathPkg::SEQ_IDLE;
		endcase
	end

	assign writing = (step == dataPathPkg::SEQ_WRITEBACK);

	assign memAddr = cur.addr;
	assign memWrite = writing
		&& (cur.op == dataPathPkg::CMD_MEMWRITE || cur.op == dataPathPkg::CMD_STORE);
	assign memWriteData = (cur.op == dataPathPkg::CMD_STORE) ? busA : cur.data;

	assign selA = cur.srcA;
	assign selB = cur.srcB;
	assign aluCtrl = cur.fn;

	assign regWrite = writing && cur.dest != '0
		&& (cur.op == dataPathPkg::CMD_LOAD || cur.op == dataPathPkg::CMD_ALU);
	assign regWriteSel = cur.dest;
	assign regWriteData = (cur.op == dataPathPkg::CMD_LOAD) ? memReadData : aluOut;

	always_ff @(posedge clk) begin
		if (accept) begin
			cmdReg <= cmd;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= dataPathPkg::SEQ_IDLE;
			result <= '0;
			flags <= '0;
		end else begin
			state <= stateNext;
			if (writing) begin
				result <= memWrite ? memWriteData : regWriteData;
			end
			if (writing && cur.op == dataPathPkg::CMD_ALU) begin
				flags <= aluFlagsIn; // Flags hold across non-ALU commands.
			end
		end
	end

endmodule

//--- alu.sv
`timescale 1ns/10ps
`include "dataPath_defines.svh"

module alu (
	input  logic [`WORD_W-1:0] a,
	input  logic [`WORD_W-1:0] b,
	input  dataPathPkg::aluOp  ctrl,
	output logic [`WORD_W-1:0] y,
	output dataPathPkg::aluFlags flags
);

	logic               subtract;
	logic [`WORD_W-1:0] bOperand;
	logic [`WORD_W:0]   sum;
	logic               signedOvf;

	// One adder serves add, subtract and the signed compare.
	assign subtract = (ctrl == dataPathPkg::ALU_SUB) || (ctrl == dataPathPkg::ALU_SLT);
	assign bOperand = subtract ? ~b : b;
	assign sum = {1'b0, a} + {1'b0, bOperand} + {{`WORD_W{1'b0}}, subtract};

	// Overflow when both inputs share a sign that the sum does not.
	assign signedOvf = (a[`WORD_W-1] == bOperand[`WORD_W-1])
		&& (sum[`WORD_W-1] != a[`WORD_W-1]);

	always_comb begin
		y = '0;
		flags = '0;
		case (ctrl)
			dataPathPkg::ALU_ADD, dataPathPkg::ALU_SUB: begin
				y = sum[`WORD_W-1:0];
				flags.carryOut = sum[`WORD_W]; // On subtract this is 1 when no borrow.
				flags.overflow = signedOvf;
			end
			dataPathPkg::ALU_AND: y = a & b;
			dataPathPkg::ALU_OR: y = a | b;
			dataPathPkg::ALU_XOR: y = a ^ b;
			dataPathPkg::ALU_SLT: begin
				y = {{(`WORD_W-1){1'b0}}, sum[`WORD_W-1] ^ signedOvf};
			end
			dataPathPkg::ALU_PASSA: y = a;
			dataPathPkg::ALU_PASSB: y = b;
			default: y = '0;
		endcase
		flags.zero = (y == '0);
		flags.negative = y[`WORD_W-1];
	end

endmodule

//--- registerFile.sv
`timescale 1ns/10ps
`include "dataPath_defines.svh"

module registerFile (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [`REG_SEL_W-1:0] selA,
	input  logic [`REG_SEL_W-1:0] selB,
	input  logic                  writeEn,
	input  logic [`REG_SEL_W-1:0] writeSel,
	input  logic [`WORD_W-1:0]    writeData,
	output logic [`WORD_W-1:0]    busA,
	output logic [`WORD_W-1:0]    busB
);

	logic [`WORD_W-1:0] regs [`REG_COUNT];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && writeSel != '0) begin
			regs[writeSel] <= writeData; // Register 0 is never written.
		end
	end

	// Register 0 reads as zero.
	assign busA = (selA == '0) ? '0 : regs[selA];
	assign busB = (selB == '0) ? '0 : regs[selB];

endmodule

//--- wordMemory.sv
`timescale 1ns/10ps
`include "dataPath_defines.svh"

module wordMemory (
	input  logic                   clk,
	input  logic [`MEM_ADDR_W-1:0] addr,
	input  logic                   writeEn,
	input  logic [`WORD_W-1:0]     writeData,
	output logic [`WORD_W-1:0]     readData
);

	logic [`WORD_W-1:0] mem [`MEM_DEPTH];

	always_ff @(posedge clk) begin
		if (writeEn) begin
			mem[addr] <= writeData;
		end
	end

	// Read-first, so a write shows up on the following read.
	always_ff @(posedge clk) begin
		readData <= mem[addr];
	end

endmodule

//--- dataPathPkg.sv
`include "dataPath_defines.svh"

package dataPathPkg;

	typedef enum logic [1:0] {
		CMD_MEMWRITE = 2'd0, // Write cmd.data into memory.
		CMD_LOAD     = 2'd1, // Memory word into a register.
		CMD_STORE    = 2'd2, // Register into memory.
		CMD_ALU      = 2'd3  // Register op register into a register.
	} cmdOp;

	typedef enum logic [`ALU_CTRL_W-1:0] {
		ALU_ADD   = 3'd0,
		ALU_SUB   = 3'd1,
		ALU_AND   = 3'd2,
		ALU_OR    = 3'd3,
		ALU_XOR   = 3'd4,
		ALU_SLT   = 3'd5, // Signed compare, result is 1 or 0.
		ALU_PASSA = 3'd6,
		ALU_PASSB = 3'd7
	} aluOp;

	typedef enum logic [1:0] {
		SEQ_IDLE      = 2'd0,
		SEQ_READ      = 2'd1,
		SEQ_WRITEBACK = 2'd2,
		SEQ_DONE      = 2'd3
	} seqState;

	typedef struct packed {
		cmdOp                  op;
		aluOp                  fn;
		logic [`MEM_ADDR_W-1:0] addr;
		logic [`REG_SEL_W-1:0]  srcA;
		logic [`REG_SEL_W-1:0]  srcB;
		logic [`REG_SEL_W-1:0]  dest;
		logic [`WORD_W-1:0]     data;
	} dpCommand;

	typedef struct packed {
		logic zero;
		logic negative;
		logic carryOut;
		logic overflow;
	} aluFlags;

endpackage

//--- dataPath_defines.svh
`ifndef DATAPATH_DEFINES_SVH
`define DATAPATH_DEFINES_SVH

// Data word width.
`define WORD_W 32

// Word memory geometry.
`define MEM_DEPTH 2048
`define MEM_ADDR_W 11

// Register file geometry.
`define REG_COUNT 32
`define REG_SEL_W 5

// Width of the ALU operation select.
`define ALU_CTRL_W 3

`endif
